// ==== rtl/pipe_cfg_pkg.sv ====
// sizing constants of the rename front end
//   widths of the dispatch group and the buffer
//   register file sizes and free pool size
//   fetch address step

package pipe_cfg_pkg;

    ////////////////////////////////////////
    // group and buffer
    ////////////////////////////////////////
    localparam int dispatch_width  = 2;     // renamed per cycle
    localparam int inst_buff_depth = 8;

    ////////////////////////////////////////
    // register files
    ////////////////////////////////////////
    localparam int arch_reg_count = 32;
    localparam int phys_reg_count = 64;
    localparam int free_reg_count = phys_reg_count - arch_reg_count;

    localparam int pc_step = 4;             // fetch never redirects

endpackage

// ==== rtl/rename_types_pkg.sv ====
// vector types shared by the front end
//   register indices, instruction address
//   buffer pointer and the small counters

package rename_types_pkg;

    // register indices
    typedef logic [$clog2(pipe_cfg_pkg::arch_reg_count)-1:0] arch_reg_t;
    typedef logic [$clog2(pipe_cfg_pkg::phys_reg_count)-1:0] phys_reg_t;

    typedef logic [31:0] addr_t;

    // instruction buffer
    typedef logic [$clog2(pipe_cfg_pkg::inst_buff_depth)-1:0] buff_idx_t;
    typedef logic [$clog2(pipe_cfg_pkg::inst_buff_depth+1)-1:0] credit_t;   // 0 to depth

    // counts within one dispatch group, 0 to 2
    typedef logic [$clog2(pipe_cfg_pkg::dispatch_width+1)-1:0] group_cnt_t;

    // free list fill, 0 to free_reg_count
    typedef logic [$clog2(pipe_cfg_pkg::free_reg_count+1)-1:0] free_cnt_t;

endpackage

// ==== rtl/fetch_intake.sv ====
// fetch intake
//   one instruction per cycle, stamped with its address
//   credit counter toward the instruction buffer

module fetch_intake (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        in_valid,
    input  rename_types_pkg::arch_reg_t in_dest,
    input  rename_types_pkg::arch_reg_t in_src1,
    input  rename_types_pkg::arch_reg_t in_src2,
    output logic                        in_ready,
    input  rename_types_pkg::group_cnt_t credit_return,
    output logic                        wr_valid,
    output rename_types_pkg::addr_t     wr_addr,
    output rename_types_pkg::arch_reg_t wr_dest,
    output rename_types_pkg::arch_reg_t wr_src1,
    output rename_types_pkg::arch_reg_t wr_src2
);

    rename_types_pkg::credit_t credit_count;
    rename_types_pkg::addr_t   next_pc;
    logic                      accept;

    assign in_ready = (credit_count != '0);
    assign accept   = in_valid && in_ready;

    // credits and address
    always_ff @(posedge clock) begin
        if (reset) begin
            credit_count <= rename_types_pkg::credit_t'(pipe_cfg_pkg::inst_buff_depth);
            next_pc      <= '0;
            wr_valid     <= 1'b0;
        end else begin
            credit_count <= credit_count - rename_types_pkg::credit_t'(accept)
                          + rename_types_pkg::credit_t'(credit_return); // spend and refill
            if (accept)
                next_pc <= next_pc + rename_types_pkg::addr_t'(pipe_cfg_pkg::pc_step);
            wr_valid <= accept;
        end
    end

    // payload toward the buffer
    always_ff @(posedge clock) begin
        if (accept) begin
            wr_addr <= next_pc;
            wr_dest <= in_dest;
            wr_src1 <= in_src1;
            wr_src2 <= in_src2;
        end
    end

endmodule

// ==== rtl/inst_buffer.sv ====
// instruction buffer
//   circular queue, one push and up to two pops per cycle
//   two oldest entries shown combinationally
//   popped count returned as credits one cycle later

module inst_buffer (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          wr_valid,
    input  rename_types_pkg::addr_t       wr_addr,
    input  rename_types_pkg::arch_reg_t   wr_dest,
    input  rename_types_pkg::arch_reg_t   wr_src1,
    input  rename_types_pkg::arch_reg_t   wr_src2,
    input  rename_types_pkg::group_cnt_t  take_count,
    output logic [pipe_cfg_pkg::dispatch_width-1:0] head_valid,
    output rename_types_pkg::addr_t     [pipe_cfg_pkg::dispatch_width-1:0] head_addr,
    output rename_types_pkg::arch_reg_t [pipe_cfg_pkg::dispatch_width-1:0] head_dest,
    output rename_types_pkg::arch_reg_t [pipe_cfg_pkg::dispatch_width-1:0] head_src1,
    output rename_types_pkg::arch_reg_t [pipe_cfg_pkg::dispatch_width-1:0] head_src2,
    output rename_types_pkg::group_cnt_t credit_return
);

    // storage
    rename_types_pkg::addr_t     mem_addr [pipe_cfg_pkg::inst_buff_depth];
    rename_types_pkg::arch_reg_t mem_dest [pipe_cfg_pkg::inst_buff_depth];
    rename_types_pkg::arch_reg_t mem_src1 [pipe_cfg_pkg::inst_buff_depth];
    rename_types_pkg::arch_reg_t mem_src2 [pipe_cfg_pkg::inst_buff_depth];

    rename_types_pkg::buff_idx_t head;
    rename_types_pkg::buff_idx_t tail;
    rename_types_pkg::buff_idx_t head_next;   // second oldest
    rename_types_pkg::credit_t   count;

    ////////////////////////////////////////
    // head view
    ////////////////////////////////////////
    assign head_next = head + 1'b1;  // wraps with the pointer width

    always_comb begin
        head_valid[0] = (count != '0);
        head_valid[1] = (count > rename_types_pkg::credit_t'(1));
        head_addr[0]  = mem_addr[head];
        head_dest[0]  = mem_dest[head];
        head_src1[0]  = mem_src1[head];
        head_src2[0]  = mem_src2[head];
        head_addr[1]  = mem_addr[head_next];
        head_dest[1]  = mem_dest[head_next];
        head_src1[1]  = mem_src1[head_next];
        head_src2[1]  = mem_src2[head_next];
    end

    ////////////////////////////////////////
    // pointers, count, credits
    ////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            head          <= '0;
            tail          <= '0;
            count         <= '0;
            credit_return <= '0;
        end else begin
            head  <= head + rename_types_pkg::buff_idx_t'(take_count);
            tail  <= tail + rename_types_pkg::buff_idx_t'(wr_valid);
            count <= count + rename_types_pkg::credit_t'(wr_valid)
                   - rename_types_pkg::credit_t'(take_count);
            credit_return <= take_count;    // slots freed this edge
        end
    end

    // push, a free slot is guaranteed by the credits
    always_ff @(posedge clock) begin
        if (wr_valid) begin
            mem_addr[tail] <= wr_addr;
            mem_dest[tail] <= wr_dest;
            mem_src1[tail] <= wr_src1;
            mem_src2[tail] <= wr_src2;
        end
    end

endmodule

// ==== rtl/map_table.sv ====
// map table
//   architectural to physical map, identity after reset
//   two-wide lookup with bypass from slot 0 to slot 1
//   in-order write of the renamed destinations

module map_table (
    input  logic clock,
    input  logic reset,
    input  rename_types_pkg::arch_reg_t [pipe_cfg_pkg::dispatch_width-1:0] look_src1,
    input  rename_types_pkg::arch_reg_t [pipe_cfg_pkg::dispatch_width-1:0] look_src2,
    input  rename_types_pkg::arch_reg_t [pipe_cfg_pkg::dispatch_width-1:0] look_dest,
    input  rename_types_pkg::phys_reg_t [pipe_cfg_pkg::dispatch_width-1:0] new_phys,
    input  rename_types_pkg::group_cnt_t                                   write_count,
    output rename_types_pkg::phys_reg_t [pipe_cfg_pkg::dispatch_width-1:0] src1_phys,
    output rename_types_pkg::phys_reg_t [pipe_cfg_pkg::dispatch_width-1:0] src2_phys,
    output rename_types_pkg::phys_reg_t [pipe_cfg_pkg::dispatch_width-1:0] old_phys
);

    rename_types_pkg::phys_reg_t map [pipe_cfg_pkg::arch_reg_count];
    logic                        slot0_wr;

    assign slot0_wr = (write_count != '0);

    // lookups, slot 1 sees slot 0's new mapping
    always_comb begin
        src1_phys[0] = map[look_src1[0]];
        src2_phys[0] = map[look_src2[0]];
        old_phys[0]  = map[look_dest[0]];

        src1_phys[1] = map[look_src1[1]];
        src2_phys[1] = map[look_src2[1]];
        old_phys[1]  = map[look_dest[1]];
        if (slot0_wr && look_src1[1] == look_dest[0]) src1_phys[1] = new_phys[0];
        if (slot0_wr && look_src2[1] == look_dest[0]) src2_phys[1] = new_phys[0];
        if (slot0_wr && look_dest[1] == look_dest[0]) old_phys[1]  = new_phys[0];
    end

    // update, slot 1 written last so it wins on a shared destination
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < pipe_cfg_pkg::arch_reg_count; i++)
                map[i] <= rename_types_pkg::phys_reg_t'(i);
        end else begin
            if (slot0_wr)
                map[look_dest[0]] <= new_phys[0];
            if (write_count == rename_types_pkg::group_cnt_t'(2))
                map[look_dest[1]] <= new_phys[1];
        end
    end

endmodule

// ==== rtl/free_list.sv ====
// free list
//   circular queue of free physical registers
//   preloaded with the registers above the architectural range
//   pops at the head, retired tags pushed at the tail in slot order

module free_list (
    input  logic                         clock,
    input  logic                         reset,
    input  rename_types_pkg::group_cnt_t pop_count,
    input  rename_types_pkg::group_cnt_t push_count,
    input  rename_types_pkg::phys_reg_t [pipe_cfg_pkg::dispatch_width-1:0] push_regs,
    output rename_types_pkg::phys_reg_t [pipe_cfg_pkg::dispatch_width-1:0] head_regs,
    output rename_types_pkg::free_cnt_t  occupancy
);

    localparam int ptr_w = $clog2(pipe_cfg_pkg::free_reg_count);

    rename_types_pkg::phys_reg_t entries [pipe_cfg_pkg::free_reg_count];
    logic [ptr_w-1:0]            head;
    logic [ptr_w-1:0]            tail;
    logic [ptr_w-1:0]            head_next;
    logic [ptr_w-1:0]            tail_next;

    assign head_next = head + 1'b1;
    assign tail_next = tail + 1'b1;

    assign head_regs[0] = entries[head];
    assign head_regs[1] = entries[head_next];

    ////////////////////////////////////////
    // queue state
    ////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            head      <= '0;
            tail      <= '0;        // full, tail meets head
            occupancy <= rename_types_pkg::free_cnt_t'(pipe_cfg_pkg::free_reg_count);
        end else begin
            head      <= head + ptr_w'(pop_count);
            tail      <= tail + ptr_w'(push_count);
            occupancy <= occupancy + rename_types_pkg::free_cnt_t'(push_count)
                       - rename_types_pkg::free_cnt_t'(pop_count);
        end
    end

    // preload at reset, then retired tags land at the tail
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < pipe_cfg_pkg::free_reg_count; i++)
                entries[i] <= rename_types_pkg::phys_reg_t'(pipe_cfg_pkg::arch_reg_count + i);
        end else begin
            if (push_count != '0)
                entries[tail] <= push_regs[0];
            if (push_count == rename_types_pkg::group_cnt_t'(2))
                entries[tail_next] <= push_regs[1];
        end
    end

endmodule

// ==== rtl/rename_stage.sv ====
// rename stage
//   dispatch count from buffer, group width and free registers
//   map table and free list lookups
//   registered output group, packed from slot 0

module rename_stage (
    input  logic clock,
    input  logic reset,
    input  logic [pipe_cfg_pkg::dispatch_width-1:0]                        head_valid,
    input  rename_types_pkg::addr_t     [pipe_cfg_pkg::dispatch_width-1:0] head_addr,
    input  rename_types_pkg::arch_reg_t [pipe_cfg_pkg::dispatch_width-1:0] head_dest,
    input  rename_types_pkg::arch_reg_t [pipe_cfg_pkg::dispatch_width-1:0] head_src1,
    input  rename_types_pkg::arch_reg_t [pipe_cfg_pkg::dispatch_width-1:0] head_src2,
    output rename_types_pkg::group_cnt_t                                   take_count,
    input  rename_types_pkg::group_cnt_t                                   retire_count,
    input  rename_types_pkg::phys_reg_t [pipe_cfg_pkg::dispatch_width-1:0] retire_tags,
    output logic [pipe_cfg_pkg::dispatch_width-1:0]                        out_valid,
    output rename_types_pkg::addr_t     [pipe_cfg_pkg::dispatch_width-1:0] out_addr,
    output rename_types_pkg::arch_reg_t [pipe_cfg_pkg::dispatch_width-1:0] out_dest,
    output rename_types_pkg::phys_reg_t [pipe_cfg_pkg::dispatch_width-1:0] out_new_phys,
    output rename_types_pkg::phys_reg_t [pipe_cfg_pkg::dispatch_width-1:0] out_old_phys,
    output rename_types_pkg::phys_reg_t [pipe_cfg_pkg::dispatch_width-1:0] out_src1_phys,
    output rename_types_pkg::phys_reg_t [pipe_cfg_pkg::dispatch_width-1:0] out_src2_phys
);

    rename_types_pkg::phys_reg_t [pipe_cfg_pkg::dispatch_width-1:0] free_regs;
    rename_types_pkg::phys_reg_t [pipe_cfg_pkg::dispatch_width-1:0] src1_phys;
    rename_types_pkg::phys_reg_t [pipe_cfg_pkg::dispatch_width-1:0] src2_phys;
    rename_types_pkg::phys_reg_t [pipe_cfg_pkg::dispatch_width-1:0] old_phys;
    rename_types_pkg::free_cnt_t                                    free_count;

    ////////////////////////////////////////
    // dispatch count
    ////////////////////////////////////////
    always_comb begin
        rename_types_pkg::group_cnt_t avail;
        avail = head_valid[1] ? 2'd2 : (head_valid[0] ? 2'd1 : 2'd0);  // one per head slot
        if (rename_types_pkg::free_cnt_t'(avail) > free_count)
            avail = rename_types_pkg::group_cnt_t'(free_count);   // free list runs dry
        take_count = avail;
    end

    map_table i_map_table (
        .clock(clock), .reset(reset),
        .look_src1(head_src1), .look_src2(head_src2), .look_dest(head_dest),
        .new_phys(free_regs), .write_count(take_count),
        .src1_phys(src1_phys), .src2_phys(src2_phys), .old_phys(old_phys)
    );

    free_list i_free_list (
        .clock(clock), .reset(reset),
        .pop_count(take_count), .push_count(retire_count), .push_regs(retire_tags),
        .head_regs(free_regs), .occupancy(free_count)
    );

    // output group
    always_ff @(posedge clock) begin
        if (reset) out_valid <= '0;
        else       out_valid <= {take_count[1], take_count != '0};  // 0, 01 or 11
    end

    always_ff @(posedge clock) begin
        out_addr      <= head_addr;
        out_dest      <= head_dest;
        out_new_phys  <= free_regs;
        out_old_phys  <= old_phys;
        out_src1_phys <= src1_phys;
        out_src2_phys <= src2_phys;
    end

endmodule

// ==== rtl/front_end.sv ====
// front end top level
//   fetch intake, instruction buffer and rename stage
//   credit loop between intake and buffer

module front_end (
    input  logic clock,
    input  logic reset,
    input  logic                        in_valid,
    input  rename_types_pkg::arch_reg_t in_dest,
    input  rename_types_pkg::arch_reg_t in_src1,
    input  rename_types_pkg::arch_reg_t in_src2,
    output logic                        in_ready,
    input  rename_types_pkg::group_cnt_t                                   retire_count,
    input  rename_types_pkg::phys_reg_t [pipe_cfg_pkg::dispatch_width-1:0] retire_tags,
    output logic [pipe_cfg_pkg::dispatch_width-1:0]                        out_valid,
    output rename_types_pkg::addr_t     [pipe_cfg_pkg::dispatch_width-1:0] out_addr,
    output rename_types_pkg::arch_reg_t [pipe_cfg_pkg::dispatch_width-1:0] out_dest,
    output rename_types_pkg::phys_reg_t [pipe_cfg_pkg::dispatch_width-1:0] out_new_phys,
    output rename_types_pkg::phys_reg_t [pipe_cfg_pkg::dispatch_width-1:0] out_old_phys,
    output rename_types_pkg::phys_reg_t [pipe_cfg_pkg::dispatch_width-1:0] out_src1_phys,
    output rename_types_pkg::phys_reg_t [pipe_cfg_pkg::dispatch_width-1:0] out_src2_phys
);

    // intake to buffer
    logic                         wr_valid;
    rename_types_pkg::addr_t      wr_addr;
    rename_types_pkg::arch_reg_t  wr_dest, wr_src1, wr_src2;
    rename_types_pkg::group_cnt_t credit_return;

    // buffer to rename
    logic [pipe_cfg_pkg::dispatch_width-1:0]                        head_valid;
    rename_types_pkg::addr_t     [pipe_cfg_pkg::dispatch_width-1:0] head_addr;
    rename_types_pkg::arch_reg_t [pipe_cfg_pkg::dispatch_width-1:0] head_dest;
    rename_types_pkg::arch_reg_t [pipe_cfg_pkg::dispatch_width-1:0] head_src1;
    rename_types_pkg::arch_reg_t [pipe_cfg_pkg::dispatch_width-1:0] head_src2;
    rename_types_pkg::group_cnt_t                                   take_count;

    fetch_intake i_fetch_intake (
        .clock(clock), .reset(reset),
        .in_valid(in_valid), .in_dest(in_dest), .in_src1(in_src1), .in_src2(in_src2),
        .in_ready(in_ready), .credit_return(credit_return),
        .wr_valid(wr_valid), .wr_addr(wr_addr),
        .wr_dest(wr_dest), .wr_src1(wr_src1), .wr_src2(wr_src2)
    );

    inst_buffer i_inst_buffer (
        .clock(clock), .reset(reset),
        .wr_valid(wr_valid), .wr_addr(wr_addr),
        .wr_dest(wr_dest), .wr_src1(wr_src1), .wr_src2(wr_src2),
        .take_count(take_count),
        .head_valid(head_valid), .head_addr(head_addr),
        .head_dest(head_dest), .head_src1(head_src1), .head_src2(head_src2),
        .credit_return(credit_return)
    );

    rename_stage i_rename_stage (
        .clock(clock), .reset(reset),
        .head_valid(head_valid), .head_addr(head_addr),
        .head_dest(head_dest), .head_src1(head_src1), .head_src2(head_src2),
        .take_count(take_count),
        .retire_count(retire_count), .retire_tags(retire_tags),
        .out_valid(out_valid), .out_addr(out_addr), .out_dest(out_dest),
        .out_new_phys(out_new_phys), .out_old_phys(out_old_phys),
        .out_src1_phys(out_src1_phys), .out_src2_phys(out_src2_phys)
    );

endmodule

// ==== tests/front_end_properties.sv ====
// concurrent checks bound to the front end top level
//   output group packed from slot 0
//   credit and free list bounds, output cleared by reset

module front_end_properties (
    input logic                                    clock,
    input logic                                    reset,
    input logic [pipe_cfg_pkg::dispatch_width-1:0] out_valid,
    input rename_types_pkg::credit_t               credit_count,
    input rename_types_pkg::free_cnt_t             free_count
);

    packed_group: assert property (@(posedge clock) disable iff (reset)
        out_valid[1] |-> out_valid[0])
        else $error("out_valid slot 1 set while slot 0 is empty");

    // the intake never holds more credits than buffer slots
    credit_bound: assert property (@(posedge clock) disable iff (reset)
        credit_count <= rename_types_pkg::credit_t'(pipe_cfg_pkg::inst_buff_depth))
        else $error("intake credit count above buffer depth");

    free_bound: assert property (@(posedge clock) disable iff (reset)
        free_count <= rename_types_pkg::free_cnt_t'(pipe_cfg_pkg::free_reg_count))
        else $error("free list occupancy above its size");

    reset_clears_output: assert property (@(posedge clock)
        reset |=> out_valid == '0)   // sync reset, so seen one edge later
        else $error("out_valid not cleared after reset");

endmodule

bind front_end front_end_properties i_front_end_properties (
    .clock(clock), .reset(reset), .out_valid(out_valid),
    .credit_count(i_fetch_intake.credit_count),
    .free_count(i_rename_stage.i_free_list.occupancy)
);

// ==== tests/front_end_tb.sv ====
// front end testbench
//   clock, reset, random requests and in-order retirement
//   sequential rename model with typed compare tasks
//   cycle limit on the whole run

module front_end_tb;

    localparam int total_requests = 2000;
    localparam int hold_after     = 600;    // accepted count that starts the retire hold
    localparam int hold_cycles    = 100;
    localparam int quiet_cycles   = pipe_cfg_pkg::inst_buff_depth + 3;  // intake, buffer, output
    localparam int timeout_cycles = 10000;  // ~2900 request cycles plus hold and drain

    logic                                    clock;
    logic                                    reset;
    logic                                    in_valid;
    rename_types_pkg::arch_reg_t             in_dest, in_src1, in_src2;
    logic                                    in_ready;
    rename_types_pkg::group_cnt_t            retire_count;
    rename_types_pkg::phys_reg_t [pipe_cfg_pkg::dispatch_width-1:0] retire_tags;
    logic [pipe_cfg_pkg::dispatch_width-1:0] out_valid;
    rename_types_pkg::addr_t     [pipe_cfg_pkg::dispatch_width-1:0] out_addr;
    rename_types_pkg::arch_reg_t [pipe_cfg_pkg::dispatch_width-1:0] out_dest;
    rename_types_pkg::phys_reg_t [pipe_cfg_pkg::dispatch_width-1:0] out_new_phys;
    rename_types_pkg::phys_reg_t [pipe_cfg_pkg::dispatch_width-1:0] out_old_phys;
    rename_types_pkg::phys_reg_t [pipe_cfg_pkg::dispatch_width-1:0] out_src1_phys;
    rename_types_pkg::phys_reg_t [pipe_cfg_pkg::dispatch_width-1:0] out_src2_phys;

    // model state
    rename_types_pkg::phys_reg_t model_map [pipe_cfg_pkg::arch_reg_count];
    rename_types_pkg::phys_reg_t free_q [$];
    rename_types_pkg::phys_reg_t retire_q [$];     // old regs of instructions seen at the output
    rename_types_pkg::addr_t     pend_addr [$];
    rename_types_pkg::arch_reg_t pend_dest [$];
    rename_types_pkg::arch_reg_t pend_src1 [$];
    rename_types_pkg::arch_reg_t pend_src2 [$];
    rename_types_pkg::addr_t     model_pc;
    int seed;
    int accepted, out_count, hold_left;
    int cycle_count = 0;
    logic hold_started, saw_stall;

    front_end i_front_end (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > timeout_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
            abort_run();
        end
    end

    ////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////
    task automatic abort_run();
        $display("Simulation FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_addr(input rename_types_pkg::addr_t got, exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_arch(input rename_types_pkg::arch_reg_t got, exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_phys(input rename_types_pkg::phys_reg_t got, exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_group(input rename_types_pkg::group_cnt_t got, exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            abort_run();
        end
    endtask

    ////////////////////////////////////////
    // model and stimulus
    ////////////////////////////////////////
    function automatic rename_types_pkg::arch_reg_t random_reg();
        logic [31:0] r;
        r = $random(seed);
        return r[8] ? rename_types_pkg::arch_reg_t'(r[2:0]) : r[4:0];  // narrow range shares regs
    endfunction

    // rename each output slot in order against the model map
    task automatic check_outputs();
        rename_types_pkg::group_cnt_t n;
        rename_types_pkg::group_cnt_t limit;
        rename_types_pkg::arch_reg_t  d;
        rename_types_pkg::arch_reg_t  s1;
        rename_types_pkg::arch_reg_t  s2;
        rename_types_pkg::phys_reg_t  fresh;
        n = rename_types_pkg::group_cnt_t'(out_valid[0])
          + rename_types_pkg::group_cnt_t'(out_valid[1]);
        limit = (pend_addr.size() < n) ? rename_types_pkg::group_cnt_t'(pend_addr.size()) : n;
        check_group(n, limit, "output count against pending instructions");
        for (int i = 0; i < n; i++) begin
            if (free_q.size() == 0) begin
                $display("Output slot %0d took a register while the model free list was empty", i);
                abort_run();
            end
            d     = pend_dest.pop_front();
            s1    = pend_src1.pop_front();
            s2    = pend_src2.pop_front();
            fresh = free_q.pop_front();
            check_addr(out_addr[i], pend_addr.pop_front(), "out_addr");
            check_arch(out_dest[i], d, "out_dest");
            check_phys(out_src1_phys[i], model_map[s1], "out_src1_phys");
            check_phys(out_src2_phys[i], model_map[s2], "out_src2_phys");
            check_phys(out_old_phys[i], model_map[d], "out_old_phys");
            check_phys(out_new_phys[i], fresh, "out_new_phys");
            retire_q.push_back(model_map[d]);
            model_map[d] = fresh;
            out_count++;
        end
    endtask

    task automatic drive_retire();
        int want;
        want = (hold_left > 0) ? 0 : {$random(seed)} % 3;
        if (want > retire_q.size())
            want = retire_q.size();
        retire_count = rename_types_pkg::group_cnt_t'(want);
        retire_tags  = '0;
        for (int i = 0; i < want; i++) begin
            retire_tags[i] = retire_q.pop_front();
            free_q.push_back(retire_tags[i]);   // slot order
        end
    endtask

    task automatic drive_request();
        in_valid = (accepted < total_requests) && ({$random(seed)} % 10 < 7);
        in_dest  = random_reg();
        in_src1  = random_reg();
        in_src2  = random_reg();
        if (in_valid && in_ready) begin      // taken on the next rising edge
            pend_addr.push_back(model_pc);
            pend_dest.push_back(in_dest);
            pend_src1.push_back(in_src1);
            pend_src2.push_back(in_src2);
            model_pc = model_pc + rename_types_pkg::addr_t'(pipe_cfg_pkg::pc_step);
            accepted++;
        end
    endtask

    initial begin
        seed         = 32'h261053e2;
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_dest      = '0;
        in_src1      = '0;
        in_src2      = '0;
        retire_count = '0;
        retire_tags  = '0;
        model_pc     = '0;
        accepted     = 0;
        out_count    = 0;
        hold_left    = 0;
        hold_started = 1'b0;
        saw_stall    = 1'b0;
        for (int i = 0; i < pipe_cfg_pkg::arch_reg_count; i++)
            model_map[i] = rename_types_pkg::phys_reg_t'(i);
        for (int i = 0; i < pipe_cfg_pkg::free_reg_count; i++)
            free_q.push_back(rename_types_pkg::phys_reg_t'(pipe_cfg_pkg::arch_reg_count + i));
        repeat (3) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        if (!in_ready) begin
            $display("in_ready is low right after reset");
            abort_run();
        end
        while (accepted < total_requests || pend_addr.size() != 0) begin
            check_outputs();
            if (!hold_started && accepted >= hold_after) begin
                hold_started = 1'b1;
                hold_left    = hold_cycles;
            end
            if (hold_left > 0) begin
                hold_left--;
                if (!in_ready)
                    saw_stall = 1'b1;
            end
            drive_retire();
            drive_request();
            @(negedge clock);
        end
        // no further output once the model queue is empty
        retire_count = '0;
        repeat (quiet_cycles) begin
            out_count = out_count + int'(out_valid[0]) + int'(out_valid[1]);
            @(negedge clock);
        end
        if (out_count == accepted && saw_stall) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            if (!saw_stall)
                $display("in_ready never dropped while retirement was withheld");
            else
                $display("Mismatch at %0t: %0d outputs for %0d accepted instructions",
                         $time, out_count, accepted);
            abort_run();
        end
    end

endmodule

// ==== sim.f ====
rtl/pipe_cfg_pkg.sv
rtl/rename_types_pkg.sv
rtl/fetch_intake.sv
rtl/inst_buffer.sv
rtl/map_table.sv
rtl/free_list.sv
rtl/rename_stage.sv
rtl/front_end.sv
tests/front_end_properties.sv
tests/front_end_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the front end testbench with Verilator and run it.
# A $fatal in the run gives a failing exit status, which set -e passes on.
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
    --top-module front_end_tb -f sim.f -o front_end_sim

./obj_dir/front_end_sim
